// ==== src/axi_bridge_pkg.sv ====
package axi_bridge_pkg;

    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int LINE_WORDS = 16;
    localparam int LINE_W     = LINE_WORDS * DATA_W;
    localparam int BEAT_CNT_W = 4;

    localparam logic [3:0] BURST_LEN = 4'd15; // 16 beats per line
    localparam logic [3:0] ICACHE_ID = 4'd0;
    localparam logic [3:0] DCACHE_ID = 4'd1;
    localparam logic [2:0] SIZE_WORD = 3'b010;

    typedef logic [LINE_W-1:0] line_t;

    typedef struct packed {
        logic              ic_refill;
        logic [ADDR_W-1:0] ic_addr;
        logic              dc_refill;
        logic [ADDR_W-1:0] dc_addr;
        logic              dc_wback;
        logic [ADDR_W-1:0] dc_wb_addr;
        line_t             dc_wb_line;
        logic              unc_en;
        logic              unc_wen;
        logic [3:0]        unc_sel; // byte select
        logic [ADDR_W-1:0] unc_addr;
        logic [DATA_W-1:0] unc_wdata;
    } cache_req_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [3:0]        len;
        logic [2:0]        size;
        logic [3:0]        id;
        logic              is_line;
    } rd_cmd_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [3:0]        len;
        logic [2:0]        size;
        logic [3:0]        strb;
        line_t             line; // single word sits in the low bits
        logic              is_line;
    } wr_cmd_t;

    typedef enum logic [1:0] {S_IDLE, S_ISSUE, S_WAIT_ENGINES, S_RESPOND} sched_state_e;
    typedef enum logic [1:0] {R_IDLE, R_ADDR, R_DATA} rd_state_e;
    typedef enum logic [1:0] {W_IDLE, W_ADDR, W_DATA, W_RESP} wr_state_e;

    function automatic logic [2:0] sel_to_size(input logic [3:0] sel);
        case (sel)
            4'b0001, 4'b0010, 4'b0100, 4'b1000: return 3'b000;
            4'b0011, 4'b1100: return 3'b001;
            default: return SIZE_WORD; // odd masks go out as a full word
        endcase
    endfunction

endpackage

// ==== src/request_scheduler.sv ====
`timescale 1ns/1ps

module request_scheduler (
    input  logic                                clk,
    input  logic                                rstn,
    input  axi_bridge_pkg::cache_req_t          req,
    input  logic                                req_valid,
    output logic                                req_ready,
    output axi_bridge_pkg::rd_cmd_t             rd_cmd,
    output logic                                rd_cmd_valid,
    input  logic                                rd_cmd_ready,
    input  logic                                rd_done,
    input  axi_bridge_pkg::line_t               rd_line,
    output axi_bridge_pkg::wr_cmd_t             wr_cmd,
    output logic                                wr_cmd_valid,
    input  logic                                wr_cmd_ready,
    input  logic                                wr_done,
    output logic                                icache_refresh,
    output axi_bridge_pkg::line_t               icache_line,
    output logic                                dcache_refresh,
    output axi_bridge_pkg::line_t               dcache_line,
    output logic                                uncache_refresh,
    output logic [axi_bridge_pkg::DATA_W-1:0]   uncache_rdata
);
    import axi_bridge_pkg::*;

    sched_state_e state;
    sched_state_e state_nxt;
    cache_req_t   req_q;
    logic         wr_todo;  // write command not yet taken
    logic         ic_todo;
    logic         dc_todo;  // dcache refill or uncached read
    logic         wr_busy;
    logic         rd_busy;
    logic         rd_is_ic; // owner of the read in flight
    logic         rd_as_line;
    logic         unc_rd;
    logic         all_done;
    line_t        ic_buf;
    line_t        dc_buf;
    line_t        ic_data;
    line_t        dc_data;

    assign unc_rd     = req_q.unc_en & ~req_q.unc_wen;
    assign all_done   = (~wr_busy | wr_done) & (~rd_busy | rd_done);
    assign rd_as_line = ic_todo | req_q.dc_refill;

    // a line returned this very cycle bypasses its buffer
    assign ic_data = (rd_done & rd_is_ic) ? rd_line : ic_buf;
    assign dc_data = (rd_done & ~rd_is_ic) ? rd_line : dc_buf;

    always_comb begin
        wr_cmd.addr    = req_q.dc_wback ? req_q.dc_wb_addr : req_q.unc_addr;
        wr_cmd.len     = req_q.dc_wback ? BURST_LEN : 4'd0;
        wr_cmd.size    = req_q.dc_wback ? SIZE_WORD : sel_to_size(req_q.unc_sel);
        wr_cmd.strb    = req_q.dc_wback ? 4'hf : req_q.unc_sel;
        wr_cmd.line    = req_q.dc_wback ? req_q.dc_wb_line : line_t'(req_q.unc_wdata);
        wr_cmd.is_line = req_q.dc_wback;
        rd_cmd.addr    = ic_todo ? req_q.ic_addr :
                         (req_q.dc_refill ? req_q.dc_addr : req_q.unc_addr);
        rd_cmd.len     = rd_as_line ? BURST_LEN : 4'd0;
        rd_cmd.size    = rd_as_line ? SIZE_WORD : sel_to_size(req_q.unc_sel);
        rd_cmd.id      = ic_todo ? ICACHE_ID : DCACHE_ID;
        rd_cmd.is_line = rd_as_line;
    end

    assign wr_cmd_valid = (state == S_ISSUE) & wr_todo;
    assign rd_cmd_valid = (state == S_ISSUE) & ~wr_todo & (ic_todo | dc_todo) & ~rd_busy;

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE:         if (req_valid && req_ready) state_nxt = S_ISSUE;
            S_ISSUE:        if (!wr_todo && !ic_todo && !dc_todo) state_nxt = S_WAIT_ENGINES;
            S_WAIT_ENGINES: if (all_done) state_nxt = S_RESPOND;
            default:        state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state     <= S_IDLE;
            req_ready <= 1'b0;
            wr_todo   <= 1'b0;
            ic_todo   <= 1'b0;
            dc_todo   <= 1'b0;
            wr_busy   <= 1'b0;
            rd_busy   <= 1'b0;
            rd_is_ic  <= 1'b0;
        end else begin
            state     <= state_nxt;
            req_ready <= (state_nxt == S_IDLE);
            if (req_valid && req_ready) begin
                wr_todo <= req.dc_wback | (req.unc_en & req.unc_wen);
                ic_todo <= req.ic_refill;
                dc_todo <= req.dc_refill | (req.unc_en & ~req.unc_wen);
            end
            if (wr_cmd_valid && wr_cmd_ready) begin
                wr_todo <= 1'b0;
                wr_busy <= 1'b1;
            end else if (wr_done) begin
                wr_busy <= 1'b0;
            end
            if (rd_cmd_valid && rd_cmd_ready) begin
                rd_busy  <= 1'b1;
                rd_is_ic <= ic_todo;
                if (ic_todo) ic_todo <= 1'b0;
                else dc_todo <= 1'b0;
            end else if (rd_done) begin
                rd_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) req_q <= req;
        if (rd_done && rd_is_ic) ic_buf <= rd_line;
        if (rd_done && !rd_is_ic) dc_buf <= rd_line;
        if (state == S_WAIT_ENGINES && all_done) begin
            if (req_q.ic_refill) icache_line <= ic_data;
            if (req_q.dc_refill) dcache_line <= dc_data;
            if (unc_rd) uncache_rdata <= dc_data[DATA_W-1:0];
        end
    end

    assign icache_refresh  = (state == S_RESPOND) & req_q.ic_refill;
    assign dcache_refresh  = (state == S_RESPOND) & req_q.dc_refill; // writeback alone is silent
    assign uncache_refresh = (state == S_RESPOND) & req_q.unc_en;

    a_accept_idle: assert property (@(posedge clk) disable iff (!rstn)
        (req_valid && req_ready) |-> (state == S_IDLE && !wr_busy && !rd_busy));

endmodule

// ==== src/read_engine.sv ====
`timescale 1ns/1ps

module read_engine (
    input  logic                                clk,
    input  logic                                rstn,
    input  axi_bridge_pkg::rd_cmd_t             rd_cmd,
    input  logic                                rd_cmd_valid,
    output logic                                rd_cmd_ready,
    output logic                                rd_done,
    output axi_bridge_pkg::line_t               rd_line,
    output logic [3:0]                          arid,
    output logic [axi_bridge_pkg::ADDR_W-1:0]   araddr,
    output logic [3:0]                          arlen,
    output logic [2:0]                          arsize,
    output logic                                arvalid,
    input  logic                                arready,
    input  logic [axi_bridge_pkg::DATA_W-1:0]   rdata,
    input  logic                                rlast,
    input  logic                                rvalid,
    output logic                                rready
);
    import axi_bridge_pkg::*;

    rd_state_e             state;
    rd_cmd_t               cmd_q;
    logic [BEAT_CNT_W-1:0] beat; // word offset of the next beat
    logic                  beat_fire;

    assign rd_cmd_ready = (state == R_IDLE);
    assign beat_fire    = rvalid & rready;

    assign arid   = cmd_q.id;
    assign araddr = cmd_q.addr;
    assign arlen  = cmd_q.len;
    assign arsize = cmd_q.size;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state   <= R_IDLE;
            arvalid <= 1'b0;
            rready  <= 1'b0;
            rd_done <= 1'b0;
            beat    <= '0;
        end else begin
            rd_done <= 1'b0;
            case (state)
                R_IDLE: begin
                    if (rd_cmd_valid) begin
                        arvalid <= 1'b1;
                        state   <= R_ADDR;
                    end
                end
                R_ADDR: begin
                    if (arready) begin
                        arvalid <= 1'b0;
                        rready  <= 1'b1;
                        beat    <= '0;
                        state   <= R_DATA;
                    end
                end
                default: begin
                    if (beat_fire) begin
                        beat <= beat + 1'b1;
                        if (rlast) begin
                            rready  <= 1'b0;
                            rd_done <= 1'b1;
                            state   <= R_IDLE;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_cmd_valid && rd_cmd_ready) cmd_q <= rd_cmd;
        if (beat_fire) rd_line[beat*DATA_W +: DATA_W] <= rdata;
    end

    a_rlast_beat15: assert property (@(posedge clk) disable iff (!rstn)
        (beat_fire && cmd_q.is_line) |-> (rlast == (beat == BEAT_CNT_W'(LINE_WORDS - 1))));

endmodule

// ==== src/write_engine.sv ====
`timescale 1ns/1ps

module write_engine (
    input  logic                                clk,
    input  logic                                rstn,
    input  axi_bridge_pkg::wr_cmd_t             wr_cmd,
    input  logic                                wr_cmd_valid,
    output logic                                wr_cmd_ready,
    output logic                                wr_done,
    output logic [axi_bridge_pkg::ADDR_W-1:0]   awaddr,
    output logic [3:0]                          awlen,
    output logic [2:0]                          awsize,
    output logic                                awvalid,
    input  logic                                awready,
    output logic [axi_bridge_pkg::DATA_W-1:0]   wdata,
    output logic [3:0]                          wstrb,
    output logic                                wlast,
    output logic                                wvalid,
    input  logic                                wready,
    input  logic                                bvalid,
    output logic                                bready
);
    import axi_bridge_pkg::*;

    wr_state_e             state;
    wr_cmd_t               cmd_q;
    logic [BEAT_CNT_W-1:0] beat; // word on the bus now
    logic [BEAT_CNT_W-1:0] beat_nxt;

    assign wr_cmd_ready = (state == W_IDLE);
    assign beat_nxt     = beat + 1'b1;

    assign awaddr = cmd_q.addr;
    assign awlen  = cmd_q.len;
    assign awsize = cmd_q.size;
    assign wstrb  = cmd_q.is_line ? 4'hf : cmd_q.strb;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state   <= W_IDLE;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            wlast   <= 1'b0;
            bready  <= 1'b0;
            wr_done <= 1'b0;
            beat    <= '0;
        end else begin
            wr_done <= 1'b0;
            case (state)
                W_IDLE: begin
                    if (wr_cmd_valid) begin
                        awvalid <= 1'b1;
                        state   <= W_ADDR;
                    end
                end
                W_ADDR: begin
                    if (awready) begin
                        awvalid <= 1'b0;
                        wvalid  <= 1'b1;
                        wlast   <= (cmd_q.len == 4'd0);
                        beat    <= '0;
                        state   <= W_DATA;
                    end
                end
                W_DATA: begin
                    if (wready) begin
                        if (wlast) begin
                            wvalid <= 1'b0;
                            wlast  <= 1'b0;
                            bready <= 1'b1;
                            state  <= W_RESP;
                        end else begin
                            wlast <= (beat_nxt == cmd_q.len);
                            beat  <= beat_nxt;
                        end
                    end
                end
                default: begin
                    if (bvalid) begin
                        bready  <= 1'b0;
                        wr_done <= 1'b1;
                        state   <= W_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_cmd_valid && wr_cmd_ready) cmd_q <= wr_cmd;
        if (state == W_ADDR && awready) wdata <= cmd_q.line[DATA_W-1:0];
        else if (state == W_DATA && wready && !wlast)
            wdata <= cmd_q.line[beat_nxt*DATA_W +: DATA_W];
    end

    a_w_hold: assert property (@(posedge clk) disable iff (!rstn)
        (wvalid && !wready) |=> (wvalid && $stable(wdata)));

endmodule

// ==== src/axi_bridge_top.sv ====
`timescale 1ns/1ps

module axi_bridge_top (
    input  logic                                clk,
    input  logic                                rstn,
    input  axi_bridge_pkg::cache_req_t          req,
    input  logic                                req_valid,
    output logic                                req_ready,
    output logic                                icache_refresh,
    output axi_bridge_pkg::line_t               icache_line,
    output logic                                dcache_refresh,
    output axi_bridge_pkg::line_t               dcache_line,
    output logic                                uncache_refresh,
    output logic [axi_bridge_pkg::DATA_W-1:0]   uncache_rdata,
    output logic [3:0]                          arid,
    output logic [axi_bridge_pkg::ADDR_W-1:0]   araddr,
    output logic [3:0]                          arlen,
    output logic [2:0]                          arsize,
    output logic                                arvalid,
    input  logic                                arready,
    input  logic [axi_bridge_pkg::DATA_W-1:0]   rdata,
    input  logic                                rlast,
    input  logic                                rvalid,
    output logic                                rready,
    output logic [axi_bridge_pkg::ADDR_W-1:0]   awaddr,
    output logic [3:0]                          awlen,
    output logic [2:0]                          awsize,
    output logic                                awvalid,
    input  logic                                awready,
    output logic [axi_bridge_pkg::DATA_W-1:0]   wdata,
    output logic [3:0]                          wstrb,
    output logic                                wlast,
    output logic                                wvalid,
    input  logic                                wready,
    input  logic                                bvalid,
    output logic                                bready
);
    import axi_bridge_pkg::*;

    rd_cmd_t rd_cmd;
    wr_cmd_t wr_cmd;
    line_t   rd_line;
    logic    rd_cmd_valid;
    logic    rd_cmd_ready;
    logic    rd_done;
    logic    wr_cmd_valid;
    logic    wr_cmd_ready;
    logic    wr_done;

    request_scheduler u_sched (.*);

    read_engine u_rd (.*);

    write_engine u_wr (.*);

endmodule

// ==== testbench/axi_slave_model.sv ====
`timescale 1ns/1ps

module axi_slave_model (
    input  logic        clk,
    input  logic        rstn,
    input  logic [31:0] araddr,
    input  logic [3:0]  arlen,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic        rlast,
    output logic        rvalid,
    input  logic        rready,
    input  logic [31:0] awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wlast,
    input  logic        wvalid,
    output logic        wready,
    output logic        bvalid,
    input  logic        bready
);
    logic [31:0] mem [0:1023];
    logic [31:0] seed;
    logic        rd_act;
    logic [9:0]  rd_idx;
    logic [3:0]  rd_left; // beats still to send after the current one
    logic        wr_act;
    logic        wr_wait_b;
    logic [9:0]  wr_idx;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    initial begin
        for (int i = 0; i < 1024; i++) begin
            mem[i] = (32'(i) * 32'h9e37_79b9) ^ 32'hc3a5_0000 ^ 32'(i);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            seed      <= 32'd96;
            arready   <= 1'b0;
            rvalid    <= 1'b0;
            rlast     <= 1'b0;
            rd_act    <= 1'b0;
            awready   <= 1'b0;
            wready    <= 1'b0;
            bvalid    <= 1'b0;
            wr_act    <= 1'b0;
            wr_wait_b <= 1'b0;
        end else begin
            seed <= lcg_next(seed);
            if (arvalid && arready) begin
                rd_act  <= 1'b1;
                rd_idx  <= araddr[11:2];
                rd_left <= arlen;
                arready <= 1'b0;
            end else begin
                arready <= !rd_act && seed[16];
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
                rlast  <= 1'b0;
                if (rd_left == 4'd0) rd_act <= 1'b0;
                else begin
                    rd_idx  <= rd_idx + 1'b1;
                    rd_left <= rd_left - 1'b1;
                end
            end else if (rd_act && !rvalid && seed[18]) begin
                rvalid <= 1'b1;
                rdata  <= mem[rd_idx];
                rlast  <= (rd_left == 4'd0);
            end
            if (awvalid && awready) begin
                wr_act  <= 1'b1;
                wr_idx  <= awaddr[11:2];
                awready <= 1'b0;
            end else begin
                awready <= !wr_act && seed[20];
            end
            if (wvalid && wready) begin
                for (int b = 0; b < 4; b++) begin
                    if (wstrb[b]) mem[wr_idx][8*b +: 8] <= wdata[8*b +: 8];
                end
                wr_idx <= wr_idx + 1'b1;
                wready <= 1'b0;
                if (wlast) wr_wait_b <= 1'b1;
            end else begin
                wready <= wr_act && !wr_wait_b && seed[22];
            end
            if (bvalid && bready) begin
                bvalid    <= 1'b0;
                wr_act    <= 1'b0;
                wr_wait_b <= 1'b0;
            end else if (wr_wait_b && !bvalid && seed[24]) begin
                bvalid <= 1'b1; // late response
            end
        end
    end

endmodule

// ==== testbench/tb_axi_bridge.sv ====
`timescale 1ns/1ps

module tb_axi_bridge;
    import axi_bridge_pkg::*;

    localparam int TIMEOUT = 3000;

    logic        clk;
    logic        rstn;
    cache_req_t  req;
    logic        req_valid;
    logic        req_ready;
    logic        icache_refresh;
    line_t       icache_line;
    logic        dcache_refresh;
    line_t       dcache_line;
    logic        uncache_refresh;
    logic [31:0] uncache_rdata;
    logic [3:0]  arid;
    logic [31:0] araddr;
    logic [3:0]  arlen;
    logic [2:0]  arsize;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic        rlast;
    logic        rvalid;
    logic        rready;
    logic [31:0] awaddr;
    logic [3:0]  awlen;
    logic [2:0]  awsize;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wlast;
    logic        wvalid;
    logic        wready;
    logic        bvalid;
    logic        bready;

    logic [31:0] shadow [0:1023];
    logic [31:0] rnd_state;
    int          errors;
    int          timeouts;
    int          pulses;
    logic        busy;      // between acceptance and the refresh pulses
    logic        exp_ic;
    logic        exp_dc;
    logic        exp_unc;
    logic        exp_unc_rd;
    line_t       exp_ic_line;
    line_t       exp_dc_line;
    logic [31:0] exp_unc_word;
    logic [2:0]  exp_awsize;
    logic [3:0]  exp_awlen;
    logic [10:0] exp_ar [2]; // arid, arlen, arsize of each read in issue order
    int          ar_cnt;

    axi_bridge_top DUT (.*);

    axi_slave_model slave (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic line_t ref_line(input logic [31:0] addr);
        line_t l;
        for (int k = 0; k < LINE_WORDS; k++) l[k*32 +: 32] = shadow[addr[11:2] + k];
        return l;
    endfunction

    // single byte, aligned half word, else a word
    function automatic logic [2:0] rule_size(input logic [3:0] sel);
        if ($countones(sel) == 1) return 3'd0;
        if (sel == 4'b0011 || sel == 4'b1100) return 3'd1;
        return 3'd2;
    endfunction

    task automatic next_rand(output logic [31:0] v);
        rnd_state = lcg_next(rnd_state);
        v = rnd_state;
    endtask

    task automatic send_req(input cache_req_t r);
        int n;
        @(posedge clk);
        #1;
        req = r;
        req_valid = 1'b1;
        n = 0;
        while (!req_ready && n < TIMEOUT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!req_ready) begin
            timeouts++;
            $display("Timed out: the bridge never accepted the request");
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        busy = 1'b1;
    endtask

    task automatic wait_resp();
        int n;
        int start;
        start = pulses;
        n = 0;
        while (pulses == start && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (pulses == start) begin
            timeouts++;
            busy = 1'b0;
            $display("Timed out: no refresh pulse came back");
        end
    endtask

    task automatic run_req(input cache_req_t r);
        logic [9:0] idx;
        if (r.dc_wback) begin
            for (int k = 0; k < LINE_WORDS; k++)
                shadow[r.dc_wb_addr[11:2] + k] = r.dc_wb_line[k*32 +: 32];
        end
        if (r.unc_en && r.unc_wen) begin
            idx = r.unc_addr[11:2];
            for (int b = 0; b < 4; b++)
                if (r.unc_sel[b]) shadow[idx][8*b +: 8] = r.unc_wdata[8*b +: 8];
        end
        exp_ic       = r.ic_refill;
        exp_dc       = r.dc_refill;
        exp_unc      = r.unc_en;
        exp_unc_rd   = r.unc_en & ~r.unc_wen;
        exp_ic_line  = ref_line(r.ic_addr);
        exp_dc_line  = ref_line(r.dc_addr);
        exp_unc_word = shadow[r.unc_addr[11:2]];
        exp_awsize   = r.dc_wback ? 3'd2 : rule_size(r.unc_sel);
        exp_awlen    = r.dc_wback ? 4'd15 : 4'd0;
        exp_ar[1]    = r.dc_refill ? {DCACHE_ID, 4'd15, 3'd2} :
                       {DCACHE_ID, 4'd0, rule_size(r.unc_sel)};
        exp_ar[0]    = r.ic_refill ? {ICACHE_ID, 4'd15, 3'd2} : exp_ar[1];
        ar_cnt       = 0;
        send_req(r);
        wait_resp();
    endtask

    always @(negedge clk) begin
        if (rstn) begin
            if (busy) assert (!req_ready) else begin
                errors++;
                $display("** Error at %0t: req_ready high while busy", $time);
            end
            if (awvalid) assert (awsize == exp_awsize && awlen == exp_awlen) else begin
                errors++;
                $display("** Error at %0t: awsize %0d awlen %0d, expected %0d %0d", $time,
                         awsize, awlen, exp_awsize, exp_awlen);
            end
            if (arvalid) assert ({arid, arlen, arsize} == exp_ar[ar_cnt]) else begin
                errors++;
                $display("** Error at %0t: AR id/len/size %h, expected %h", $time,
                         {arid, arlen, arsize}, exp_ar[ar_cnt]);
            end
            if (arvalid && arready && ar_cnt == 0) ar_cnt = 1;
            if (icache_refresh || dcache_refresh || uncache_refresh) begin
                assert (busy) else begin
                    errors++;
                    $display("** Error at %0t: refresh pulse with no request in flight", $time);
                end
                assert (icache_refresh == exp_ic && dcache_refresh == exp_dc &&
                        uncache_refresh == exp_unc) else begin
                    errors++;
                    $display("** Error at %0t: refresh set %b%b%b, expected %b%b%b", $time,
                             icache_refresh, dcache_refresh, uncache_refresh,
                             exp_ic, exp_dc, exp_unc);
                end
                if (icache_refresh) assert (icache_line == exp_ic_line) else begin
                    errors++;
                    $display("** Error at %0t: icache_line mismatch", $time);
                end
                if (dcache_refresh) assert (dcache_line == exp_dc_line) else begin
                    errors++;
                    $display("** Error at %0t: dcache_line mismatch", $time);
                end
                if (uncache_refresh && exp_unc_rd) assert (uncache_rdata == exp_unc_word)
                else begin
                    errors++;
                    $display("** Error at %0t: uncache_rdata %h, expected %h", $time,
                             uncache_rdata, exp_unc_word);
                end
                busy = 1'b0;
                pulses++;
            end
        end
    end

    initial begin
        cache_req_t  r;
        logic [31:0] v;
        logic [3:0]  sels [8];
        logic [5:0]  ln;
        rstn = 1'b0;
        req = '0;
        req_valid = 1'b0;
        busy = 1'b0;
        errors = 0;
        timeouts = 0;
        pulses = 0;
        rnd_state = 32'd96;
        {exp_ic, exp_dc, exp_unc, exp_unc_rd} = 4'b0;
        exp_awsize = 3'd2;
        exp_awlen = 4'd0;
        exp_ar[0] = 11'd0;
        exp_ar[1] = 11'd0;
        ar_cnt = 0;
        repeat (10) @(posedge clk);
        #1;
        rstn = 1'b1;
        for (int i = 0; i < 1024; i++) shadow[i] = slave.mem[i];
        @(posedge clk);
        #1;
        assert (!arvalid && !awvalid && !wvalid && !rready && !bready && !icache_refresh &&
                !dcache_refresh && !uncache_refresh && req_ready) else begin
            errors++;
            $display("** Error at %0t: outputs not in their reset values", $time);
        end

        r = '0;
        r.ic_refill = 1'b1;
        r.ic_addr = 32'h100;
        run_req(r);

        r = '0;
        r.dc_wback = 1'b1;
        r.dc_wb_addr = 32'h200;
        for (int k = 0; k < LINE_WORDS; k++) begin
            next_rand(v);
            r.dc_wb_line[k*32 +: 32] = v;
        end
        r.dc_refill = 1'b1;
        r.dc_addr = 32'h340;
        run_req(r);
        r = '0;
        r.ic_refill = 1'b1;
        r.ic_addr = 32'h200; // the line just written back
        run_req(r);

        sels = '{4'h1, 4'h2, 4'h4, 4'h8, 4'h3, 4'hc, 4'h5, 4'hf};
        for (int i = 0; i < 8; i++) begin
            r = '0;
            r.unc_en = 1'b1;
            r.unc_wen = 1'b1;
            r.unc_sel = sels[i];
            r.unc_addr = 32'h404;
            next_rand(v);
            r.unc_wdata = v;
            run_req(r);
            r.unc_wen = 1'b0;
            run_req(r);
        end

        r = '0;
        r.ic_refill = 1'b1;
        r.ic_addr = 32'h500;
        r.dc_refill = 1'b1;
        r.dc_addr = 32'h640;
        run_req(r);

        repeat (24) begin
            next_rand(v);
            ln = v[13:8];
            r = '0;
            r.ic_refill = 1'b1;
            r.ic_addr = {20'd0, ln, 6'd0};
            r.dc_refill = v[0];
            r.dc_addr = {20'd0, ln + 6'd1, 6'd0};
            r.unc_en = v[2] & ~v[0];
            r.unc_sel = 4'hf;
            r.unc_addr = {20'd0, ln + 6'd3, 6'd4};
            r.dc_wback = v[1];
            r.dc_wb_addr = {20'd0, ln + 6'd2, 6'd0};
            for (int k = 0; k < LINE_WORDS; k++) begin
                next_rand(v);
                r.dc_wb_line[k*32 +: 32] = v;
            end
            run_req(r);
        end
        repeat (2) @(posedge clk); // a stray second pulse would show here

        $display("Done: %0d errors, %0d timeouts, %0d responses", errors, timeouts, pulses);
        if (errors == 0 && timeouts == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
src/axi_bridge_pkg.sv
src/request_scheduler.sv
src/read_engine.sv
src/write_engine.sv
src/axi_bridge_top.sv
testbench/axi_slave_model.sv
testbench/tb_axi_bridge.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module tb_axi_bridge \
    -o sim_tb_axi_bridge
./obj_dir/sim_tb_axi_bridge > sim.log 2>&1 || true
cat sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
    exit 1
fi
if ! grep -qF "*** TEST PASSED ***" sim.log; then
    exit 1
fi
exit 0
